// File: design/cache_types_pkg.sv
package cache_types_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;   // one bit per byte lane

    // line geometry
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 4;   // byte offset within a line

    // words packed low to high with word 0 at bits 31:0
    typedef word_t [LINE_WORDS-1:0] line_t;

    // replacement state is a single bit per set, so two ways only
    localparam int WAYS = 2;

endpackage

// File: design/cache_bus_pkg.sv
package cache_bus_pkg;

    // CPU load/store request held by the CPU while req_valid is high
    typedef struct packed {
        logic                   write;
        logic                   cacheable;
        cache_types_pkg::addr_t addr;
        cache_types_pkg::strb_t wstrb;
        cache_types_pkg::word_t wdata;
    } cpu_req_t;

    // line write-back to memory
    typedef struct packed {
        cache_types_pkg::addr_t addr;   // line aligned
        cache_types_pkg::line_t data;
    } line_wr_t;

    // single word access on the uncached bus
    typedef struct packed {
        logic                   write;
        cache_types_pkg::addr_t addr;
        cache_types_pkg::strb_t wstrb;
        cache_types_pkg::word_t wdata;
    } word_req_t;

endpackage

// File: design/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookup_accept,
    input  cache_types_pkg::addr_t  lookup_addr,
    input  cache_bus_pkg::cpu_req_t buf_req,
    input  logic                    buf_valid,
    input  logic                    refill_we,
    input  cache_types_pkg::line_t  refill_line,
    output logic                    hit,
    output cache_types_pkg::word_t  hit_rdata,
    output logic                    victim_dirty,
    output cache_types_pkg::line_t  victim_line,
    output cache_types_pkg::addr_t  victim_addr,
    output logic                    store_pending,
    output logic [$clog2(SETS)-1:0] store_index
);
    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS   = 32 - INDEX_BITS - cache_types_pkg::OFFSET_BITS;
    localparam int WAYS       = cache_types_pkg::WAYS;

    typedef logic [INDEX_BITS-1:0]                   index_t;
    typedef logic [TAG_BITS-1:0]                     tag_t;
    typedef logic [cache_types_pkg::OFFSET_BITS-3:0] word_sel_t;

    tag_t                   tag_arr   [WAYS][SETS];
    cache_types_pkg::line_t data_arr  [WAYS][SETS];
    logic [SETS-1:0]        valid_arr [WAYS];
    logic [SETS-1:0]        dirty_arr [WAYS];
    logic [SETS-1:0]        lru;   // way to replace next

    // registered lookup stage
    tag_t                   stg_tag   [WAYS];
    logic                   stg_valid [WAYS];
    logic                   stg_dirty [WAYS];
    cache_types_pkg::line_t stg_line  [WAYS];

    logic                   sb_way;
    cache_types_pkg::line_t sb_line;

    index_t                 rd_index;
    index_t                 buf_index;
    tag_t                   buf_tag;
    word_sel_t              word_sel;
    logic [WAYS-1:0]        hit_way;
    logic [WAYS-1:0]        sb_match;
    logic [WAYS-1:0]        eff_dirty;
    cache_types_pkg::line_t eff_line  [WAYS];
    cache_types_pkg::line_t merged;
    logic                   hit_sel;
    logic                   victim_way;
    logic                   store_hit;

    function automatic cache_types_pkg::word_t merge_bytes(
        input cache_types_pkg::word_t old_word,
        input cache_types_pkg::word_t new_word,
        input cache_types_pkg::strb_t strb
    );
        cache_types_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign rd_index  = lookup_addr[cache_types_pkg::OFFSET_BITS +: INDEX_BITS];
    assign buf_index = buf_req.addr[cache_types_pkg::OFFSET_BITS +: INDEX_BITS];
    assign buf_tag   = buf_req.addr[31 -: TAG_BITS];
    assign word_sel  = buf_req.addr[cache_types_pkg::OFFSET_BITS-1:2];

    // stage contents with the not yet committed store laid over them
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            sb_match[w]  = store_pending && store_index == buf_index && sb_way == 1'(w);
            eff_line[w]  = sb_match[w] ? sb_line : stg_line[w];
            eff_dirty[w] = stg_dirty[w] | sb_match[w];
            hit_way[w]   = stg_valid[w] && stg_tag[w] == buf_tag;
        end
    end

    assign hit        = |hit_way;
    assign hit_sel    = hit_way[1];
    assign hit_rdata  = eff_line[hit_sel][word_sel];
    assign victim_way = lru[buf_index];
    assign store_hit  = buf_valid & buf_req.cacheable & buf_req.write & hit;

    assign victim_dirty = stg_valid[victim_way] & eff_dirty[victim_way];
    assign victim_line  = eff_line[victim_way];
    assign victim_addr  = {stg_tag[victim_way], buf_index,
                           {cache_types_pkg::OFFSET_BITS{1'b0}}};

    always_comb begin
        merged           = eff_line[hit_sel];
        merged[word_sel] = merge_bytes(merged[word_sel], buf_req.wdata, buf_req.wstrb);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr     <= '{default: '0};
            dirty_arr     <= '{default: '0};
            lru           <= '0;
            store_pending <= 1'b0;
        end else begin
            store_pending <= store_hit;
            if (store_pending) begin
                dirty_arr[sb_way][store_index] <= 1'b1;
            end
            if (refill_we) begin
                valid_arr[victim_way][buf_index] <= 1'b1;
                dirty_arr[victim_way][buf_index] <= 1'b0;
                lru[buf_index]                   <= ~victim_way;
            end else if (buf_valid && buf_req.cacheable && hit) begin
                lru[buf_index] <= ~hit_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            sb_way      <= hit_sel;
            store_index <= buf_index;
            sb_line     <= merged;
        end
        if (store_pending) begin
            data_arr[sb_way][store_index] <= sb_line;   // commit one cycle late
        end
        if (refill_we) begin
            tag_arr[victim_way][buf_index]  <= buf_tag;
            data_arr[victim_way][buf_index] <= refill_line;
        end
        if (lookup_accept) begin
            for (int w = 0; w < WAYS; w++) begin
                stg_tag[w]   <= tag_arr[w][rd_index];
                stg_valid[w] <= valid_arr[w][rd_index];
                stg_dirty[w] <= dirty_arr[w][rd_index];
                stg_line[w]  <= data_arr[w][rd_index];
            end
        end else if (store_pending && store_index == buf_index) begin
            // keep the stage in step with the commit
            stg_line[sb_way]  <= sb_line;
            stg_dirty[sb_way] <= 1'b1;
        end
    end

endmodule

// File: design/uncached_access.sv
`timescale 1ns/1ps

module uncached_access (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     unc_start,
    input  cache_bus_pkg::cpu_req_t  buf_req,
    output logic                     word_req_valid,
    output cache_bus_pkg::word_req_t word_req,
    input  logic                     word_rdy,
    input  logic                     word_done,
    input  cache_types_pkg::word_t   word_rdata,
    output logic                     unc_done,
    output cache_types_pkg::word_t   unc_rdata
);
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait,
        st_done
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            unique case (state)
                st_idle: begin
                    if (unc_start) begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (word_rdy) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (word_done) begin
                        state <= st_done;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // buffered request stays put for the whole access
    always_comb begin
        word_req.write = buf_req.write;
        word_req.addr  = buf_req.addr;
        word_req.wstrb = buf_req.wstrb;
        word_req.wdata = buf_req.wdata;
    end

    assign word_req_valid = state == st_request;
    assign unc_done       = state == st_done;

    always_ff @(posedge clk) begin
        if (state == st_wait && word_done) begin
            unc_rdata <= word_rdata;
        end
    end

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  cache_bus_pkg::cpu_req_t req,
    output logic                    busy,
    output logic                    resp_valid,
    output cache_types_pkg::word_t  resp_rdata,
    output logic                    lookup_accept,
    output cache_types_pkg::addr_t  lookup_addr,
    output cache_bus_pkg::cpu_req_t buf_req,
    output logic                    buf_valid,
    input  logic                    hit,
    input  cache_types_pkg::word_t  hit_rdata,
    input  logic                    victim_dirty,
    input  cache_types_pkg::line_t  victim_line,
    input  cache_types_pkg::addr_t  victim_addr,
    input  logic                    store_pending,
    input  logic [$clog2(SETS)-1:0] store_index,
    output logic                    refill_we,
    output cache_types_pkg::line_t  refill_line,
    output logic                    unc_start,
    input  logic                    unc_done,
    input  cache_types_pkg::word_t  unc_rdata,
    output logic                    line_rd_req,
    output cache_types_pkg::addr_t  line_rd_addr,
    input  logic                    line_rd_rdy,
    input  logic                    line_ret_valid,
    input  cache_types_pkg::line_t  line_ret_data,
    output logic                    line_wr_req,
    output cache_bus_pkg::line_wr_t line_wr,
    input  logic                    line_wr_rdy,
    input  logic                    line_wr_done
);
    localparam int INDEX_BITS = $clog2(SETS);

    typedef logic [INDEX_BITS-1:0] index_t;

    typedef enum logic [2:0] {
        st_lookup,
        st_miss_dirty,
        st_write_back,
        st_miss_clean,
        st_refill,
        st_refill_done,
        st_uncached
    } state_t;

    state_t state;
    state_t state_next;
    logic   buf_pending;
    logic   accept;
    logic   collision;
    index_t req_index;

    assign req_index = req.addr[cache_types_pkg::OFFSET_BITS +: INDEX_BITS];

    // store buffer still owes a write to this set
    assign collision = req_valid & store_pending & (store_index == req_index);
    assign busy      = (state != st_lookup) |
                       (buf_pending & ~(buf_req.cacheable & hit)) |
                       collision;
    assign accept    = req_valid & ~busy;

    assign resp_valid = buf_pending &
                        ((state == st_lookup & buf_req.cacheable & hit) |
                         (state == st_uncached & unc_done));
    assign resp_rdata = buf_req.write ? '0 :
                        buf_req.cacheable ? hit_rdata : unc_rdata;

    assign buf_valid     = buf_pending & (state == st_lookup);
    assign lookup_accept = accept | (state == st_refill_done);   // replay after refill
    assign lookup_addr   = (state == st_refill_done) ? buf_req.addr : req.addr;
    assign unc_start     = buf_valid & ~buf_req.cacheable;

    assign refill_we    = (state == st_refill) & line_ret_valid;
    assign refill_line  = line_ret_data;
    assign line_rd_req  = state == st_miss_clean;
    assign line_rd_addr = {buf_req.addr[31:cache_types_pkg::OFFSET_BITS],
                           {cache_types_pkg::OFFSET_BITS{1'b0}}};
    assign line_wr_req  = state == st_miss_dirty;
    assign line_wr      = '{addr: victim_addr, data: victim_line};

    always_comb begin
        state_next = state;
        unique case (state)
            st_lookup: begin
                if (buf_pending) begin
                    if (!buf_req.cacheable) begin
                        state_next = st_uncached;
                    end else if (!hit) begin
                        state_next = victim_dirty ? st_miss_dirty : st_miss_clean;
                    end
                end
            end
            st_miss_dirty:  state_next = line_wr_rdy ? st_write_back : st_miss_dirty;
            st_write_back:  state_next = line_wr_done ? st_miss_clean : st_write_back;
            st_miss_clean:  state_next = line_rd_rdy ? st_refill : st_miss_clean;
            st_refill:      state_next = line_ret_valid ? st_refill_done : st_refill;
            st_refill_done: state_next = st_lookup;
            st_uncached:    state_next = unc_done ? st_lookup : st_uncached;
            default:        state_next = st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_lookup;
            buf_pending <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                buf_pending <= 1'b1;
            end else if (resp_valid) begin
                buf_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_req <= req;
        end
    end

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int SETS = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    // CPU port
    input  logic                     req_valid,
    input  cache_bus_pkg::cpu_req_t  req,
    output logic                     busy,
    output logic                     resp_valid,
    output cache_types_pkg::word_t   resp_rdata,
    // line bus
    output logic                     line_rd_req,
    output cache_types_pkg::addr_t   line_rd_addr,
    input  logic                     line_rd_rdy,
    input  logic                     line_ret_valid,
    input  cache_types_pkg::line_t   line_ret_data,
    output logic                     line_wr_req,
    output cache_bus_pkg::line_wr_t  line_wr,
    input  logic                     line_wr_rdy,
    input  logic                     line_wr_done,
    // word bus
    output logic                     word_req_valid,
    output cache_bus_pkg::word_req_t word_req,
    input  logic                     word_rdy,
    input  logic                     word_done,
    input  cache_types_pkg::word_t   word_rdata
);
    logic                    lookup_accept;
    cache_types_pkg::addr_t  lookup_addr;
    cache_bus_pkg::cpu_req_t buf_req;
    logic                    buf_valid;
    logic                    hit;
    cache_types_pkg::word_t  hit_rdata;
    logic                    victim_dirty;
    cache_types_pkg::line_t  victim_line;
    cache_types_pkg::addr_t  victim_addr;
    logic                    store_pending;
    logic [$clog2(SETS)-1:0] store_index;
    logic                    refill_we;
    cache_types_pkg::line_t  refill_line;
    logic                    unc_start;
    logic                    unc_done;
    cache_types_pkg::word_t  unc_rdata;

    // port names line up across the three blocks
    cache_ctrl #(.SETS(SETS)) u_cache_ctrl (.*);

    cache_lookup #(.SETS(SETS)) u_cache_lookup (.*);

    uncached_access u_uncached_access (.*);

endmodule

// File: dv/cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic busy,
    input logic resp_valid,
    input logic line_rd_req,
    input logic line_rd_rdy,
    input logic line_wr_req,
    input logic line_wr_rdy,
    input logic word_req_valid,
    input logic word_rdy
);
    // request levels stay up until taken
    cpu_req_held: assert property (@(posedge clk) disable iff (rst)
        req_valid && busy |=> req_valid)
        else $error("req_valid dropped while busy");

    line_rd_held: assert property (@(posedge clk) disable iff (rst)
        line_rd_req && !line_rd_rdy |=> line_rd_req)
        else $error("line_rd_req dropped before line_rd_rdy");

    line_wr_held: assert property (@(posedge clk) disable iff (rst)
        line_wr_req && !line_wr_rdy |=> line_wr_req)
        else $error("line_wr_req dropped before line_wr_rdy");

    word_req_held: assert property (@(posedge clk) disable iff (rst)
        word_req_valid && !word_rdy |=> word_req_valid)
        else $error("word_req_valid dropped before word_rdy");

    no_resp_in_reset: assert property (@(posedge clk) $past(rst) |-> !resp_valid)
        else $error("resp_valid seen during reset");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else $error("busy high right after reset");

endmodule

bind cache_top cache_assertions u_cache_assertions (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .busy           (busy),
    .resp_valid     (resp_valid),
    .line_rd_req    (line_rd_req),
    .line_rd_rdy    (line_rd_rdy),
    .line_wr_req    (line_wr_req),
    .line_wr_rdy    (line_wr_rdy),
    .word_req_valid (word_req_valid),
    .word_rdy       (word_rdy)
);

// File: dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
    localparam int                     SETS      = 4;
    localparam int                     TAG_SHIFT = cache_types_pkg::OFFSET_BITS + $clog2(SETS);
    localparam cache_types_pkg::addr_t UNC_BASE  = 32'h0001_0000;

    typedef struct packed {
        logic                   is_load;
        cache_types_pkg::word_t data;
    } expect_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     req_valid;
    cache_bus_pkg::cpu_req_t  req;
    logic                     busy;
    logic                     resp_valid;
    cache_types_pkg::word_t   resp_rdata;
    logic                     line_rd_req;
    cache_types_pkg::addr_t   line_rd_addr;
    logic                     line_rd_rdy;
    logic                     line_ret_valid;
    cache_types_pkg::line_t   line_ret_data;
    logic                     line_wr_req;
    cache_bus_pkg::line_wr_t  line_wr;
    logic                     line_wr_rdy;
    logic                     line_wr_done;
    logic                     word_req_valid;
    cache_bus_pkg::word_req_t word_req;
    logic                     word_rdy;
    logic                     word_done;
    cache_types_pkg::word_t   word_rdata;

    cache_types_pkg::word_t line_mem [256];   // 1 KB cacheable region
    cache_types_pkg::word_t word_mem [64];    // uncached region
    cache_types_pkg::word_t shadow   [512];   // both regions

    expect_t exp_q  [$];
    string   name_q [$];
    int      seed = 32'h57cb;
    int      issued;
    int      resp_count;
    int      cycles;
    int      data_errors;
    int      count_errors;
    int      other_errors;

    cache_top #(.SETS(SETS)) u_cache_top (.*);

    always #50 clk = ~clk;

    function automatic cache_types_pkg::word_t fill_word(input cache_types_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic cache_types_pkg::word_t strobe_merge(
        input cache_types_pkg::word_t old_word,
        input cache_types_pkg::word_t new_word,
        input cache_types_pkg::strb_t strb
    );
        cache_types_pkg::word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [8:0] shadow_index(input cache_types_pkg::addr_t a);
        return (a >= UNC_BASE) ? {3'b100, a[7:2]} : {1'b0, a[9:2]};
    endfunction

    // last value stored to a word, else the preload
    function automatic cache_types_pkg::word_t expected_word(input cache_types_pkg::addr_t a);
        return shadow[shadow_index(a)];
    endfunction

    function automatic int random_delay();
        return 1 + int'($unsigned($random(seed)) % 6);
    endfunction

    function automatic cache_types_pkg::word_t random_word();
        return cache_types_pkg::word_t'($random(seed));
    endfunction

    function automatic cache_types_pkg::addr_t random_cached_addr();
        return cache_types_pkg::addr_t'($random(seed)) & 32'h0000_03fc;
    endfunction

    function automatic cache_types_pkg::addr_t random_uncached_addr();
        return UNC_BASE | (cache_types_pkg::addr_t'($random(seed)) & 32'h0000_00fc);
    endfunction

    task automatic check_word(input string name, input cache_types_pkg::word_t expected,
                              input cache_types_pkg::word_t actual);
        if (actual !== expected) begin
            data_errors++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            count_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: data %0d, count %0d, other %0d; responses %0d of %0d",
                 data_errors, count_errors, other_errors, resp_count, issued);
        if (data_errors + count_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // holds the request until the DUT takes it
    task automatic send_request(input string name, input logic write, input logic cacheable,
                                input cache_types_pkg::addr_t addr,
                                input cache_types_pkg::strb_t strb,
                                input cache_types_pkg::word_t data);
        expect_t e;
        @(negedge clk);
        req_valid = 1'b1;
        req = '{write: write, cacheable: cacheable, addr: addr, wstrb: strb, wdata: data};
        issued++;
        #1;
        while (busy) begin
            @(negedge clk);
            #1;
        end
        if (write) begin
            shadow[shadow_index(addr)] = strobe_merge(expected_word(addr), data, strb);
        end
        e.is_load = ~write;
        e.data    = write ? '0 : expected_word(addr);
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic release_request();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    always begin : line_memory
        cache_types_pkg::addr_t a;
        @(negedge clk);
        if (line_wr_req) begin
            repeat (random_delay()) @(negedge clk);
            line_wr_rdy = 1'b1;
            for (int w = 0; w < cache_types_pkg::LINE_WORDS; w++) begin
                line_mem[{line_wr.addr[9:4], 2'(w)}] = line_wr.data[2'(w)];
            end
            @(negedge clk);
            line_wr_rdy = 1'b0;
            repeat (random_delay()) @(negedge clk);
            line_wr_done = 1'b1;
            @(negedge clk);
            line_wr_done = 1'b0;
        end else if (line_rd_req) begin
            repeat (random_delay()) @(negedge clk);
            a           = line_rd_addr;
            line_rd_rdy = 1'b1;
            @(negedge clk);
            line_rd_rdy = 1'b0;
            repeat (random_delay()) @(negedge clk);
            for (int w = 0; w < cache_types_pkg::LINE_WORDS; w++) begin
                line_ret_data[2'(w)] = line_mem[{a[9:4], 2'(w)}];
            end
            line_ret_valid = 1'b1;
            @(negedge clk);
            line_ret_valid = 1'b0;
        end
    end

    always begin : word_memory
        cache_bus_pkg::word_req_t r;
        @(negedge clk);
        if (word_req_valid) begin
            repeat (random_delay()) @(negedge clk);
            r        = word_req;
            word_rdy = 1'b1;
            if (r.write) begin
                word_mem[r.addr[7:2]] = strobe_merge(word_mem[r.addr[7:2]], r.wdata, r.wstrb);
            end
            @(negedge clk);
            word_rdy = 1'b0;
            repeat (random_delay()) @(negedge clk);
            word_rdata = r.write ? '0 : word_mem[r.addr[7:2]];
            word_done  = 1'b1;
            @(negedge clk);
            word_done = 1'b0;
        end
    end

    // responses come back in request order
    always @(negedge clk) begin : compare_responses
        expect_t e;
        string   name;
        if (!rst && resp_valid) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("response arrived with no request outstanding");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                if (e.is_load) begin
                    check_word(name, e.data, resp_rdata);
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles > 40 * (issued + 4)) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d responses outstanding",
                     cycles, exp_q.size());
            finish_run();
        end
    end

    initial begin : stimulus
        cache_types_pkg::addr_t a;
        int                     set_sel;
        int                     tag_base;
        logic                   wr;
        logic                   cch;
        issued         = 0;
        resp_count     = 0;
        cycles         = 0;
        data_errors    = 0;
        count_errors   = 0;
        other_errors   = 0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        line_rd_rdy    = 1'b0;
        line_ret_valid = 1'b0;
        line_ret_data  = '0;
        line_wr_rdy    = 1'b0;
        line_wr_done   = 1'b0;
        word_rdy       = 1'b0;
        word_done      = 1'b0;
        word_rdata     = '0;
        for (int i = 0; i < 256; i++) begin
            line_mem[8'(i)] = fill_word(cache_types_pkg::addr_t'(i * 4));
            shadow[9'(i)]   = line_mem[8'(i)];
        end
        for (int i = 0; i < 64; i++) begin
            word_mem[6'(i)]     = fill_word(UNC_BASE + cache_types_pkg::addr_t'(i * 4));
            shadow[9'(256 + i)] = word_mem[6'(i)];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_request("reset_load", 1'b0, 1'b1, random_cached_addr(), '0, '0);

        a = random_cached_addr();
        send_request("store_merge", 1'b1, 1'b1, a, 4'b0110, random_word());
        send_request("store_merge", 1'b0, 1'b1, a, '0, '0);
        send_request("store_merge", 1'b0, 1'b1, a ^ 32'h4, '0, '0);
        send_request("store_merge", 1'b1, 1'b1, a ^ 32'h8, 4'b1001, random_word());
        send_request("store_merge", 1'b0, 1'b1, a ^ 32'h8, '0, '0);
        send_request("store_merge", 1'b0, 1'b1, a, '0, '0);
        release_request();

        // three tags in one set of a two-way cache
        set_sel  = int'($unsigned($random(seed)) % SETS);
        tag_base = int'($unsigned($random(seed)) % 14);
        for (int k = 0; k < 3; k++) begin
            a = cache_types_pkg::addr_t'(((tag_base + k) << TAG_SHIFT) | (set_sel << 4) | (k << 2));
            send_request("set_conflict", 1'b1, 1'b1, a, 4'b1111, random_word());
        end
        for (int k = 0; k < 3; k++) begin
            a = cache_types_pkg::addr_t'(((tag_base + k) << TAG_SHIFT) | (set_sel << 4) | (k << 2));
            send_request("set_conflict", 1'b0, 1'b1, a, '0, '0);
        end
        release_request();

        a = random_uncached_addr();
        send_request("uncached", 1'b0, 1'b0, a, '0, '0);
        send_request("uncached", 1'b1, 1'b0, a, 4'b0011, random_word());
        send_request("uncached", 1'b0, 1'b0, a, '0, '0);
        a = random_uncached_addr();
        send_request("uncached", 1'b1, 1'b0, a, 4'b1111, random_word());
        send_request("uncached", 1'b0, 1'b0, a, '0, '0);
        release_request();

        for (int i = 0; i < 300; i++) begin
            cch = ($unsigned($random(seed)) % 5) != 0;
            wr  = 1'($random(seed));
            a   = cch ? random_cached_addr() : random_uncached_addr();
            send_request("random_mix", wr, cch, a, cache_types_pkg::strb_t'($random(seed)),
                         random_word());
            if (($unsigned($random(seed)) % 8) == 0) begin
                release_request();
            end
        end
        release_request();

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        check_count("response_count", issued, resp_count);
        finish_run();
    end

endmodule

// File: build.f
design/cache_types_pkg.sv
design/cache_bus_pkg.sv
design/cache_lookup.sv
design/uncached_access.sv
design/cache_ctrl.sv
design/cache_top.sv
dv/cache_assertions.sv
dv/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_tb -f build.f

sim_out=$(./obj_dir/Vcache_tb)
echo "$sim_out"

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
    exit 0
fi
exit 1
